// File: rv_isa_pkg.sv
package rv_isa_pkg;

  // Base integer register width
  localparam int xlen = 32;

  // M-extension funct3 codes for the multiply group
  // Division codes have bit 2 set
  localparam logic [2:0] mul_op_mul    = 3'b000;
  localparam logic [2:0] mul_op_mulh   = 3'b001;
  localparam logic [2:0] mul_op_mulhsu = 3'b010;
  localparam logic [2:0] mul_op_mulhu  = 3'b011;

  // Trap cause as raised upstream, retired unchanged
  typedef logic [1:0] trap_code_t;

  // Instruction word, seen raw or split into R-type fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
  } rv_instr_u;

endpackage

// File: rv_wb_pkg.sv
package rv_wb_pkg;

  // Result source select, codes 6 and 7 unused
  localparam logic [2:0] res_alu      = 3'd0;
  localparam logic [2:0] res_load     = 3'd1;
  localparam logic [2:0] res_pc_plus4 = 3'd2;
  localparam logic [2:0] res_jb_tgt   = 3'd3;
  localparam logic [2:0] res_csr      = 3'd4;
  localparam logic [2:0] res_m_ext    = 3'd5;

  // Slots in the retire consumer buffer, also the credit count at reset
  localparam int retire_credits = 4;

  // Counter must hold every value from zero up to full
  localparam int credit_cnt_w = $clog2(retire_credits + 1);

endpackage

// File: rv_wb_if.sv
`timescale 1ns/1ps

// Bundle handed over from the memory stage
interface rv_wb_in_if import rv_isa_pkg::*; ();
  logic            instr_valid;
  logic [2:0]      res_src;
  rv_instr_u       instr;
  logic [xlen-1:0] alu_result;
  logic [xlen-1:0] ld_data;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] jb_tgt;
  logic [xlen-1:0] csr_rdata;
  logic [xlen-1:0] m_result;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [63:0]     product_64;
  logic            trap;
  trap_code_t      trap_code;
  logic            is_ebreak;
  logic            reg_write;

  modport src (
    output instr_valid, res_src, instr, alu_result, ld_data, pc_plus4, jb_tgt,
    output csr_rdata, m_result, rs1_data, rs2_data, product_64, trap, trap_code,
    output is_ebreak, reg_write
  );

  modport dst (
    input instr_valid, res_src, instr, alu_result, ld_data, pc_plus4, jb_tgt,
    input csr_rdata, m_result, rs1_data, rs2_data, product_64, trap, trap_code,
    input is_ebreak, reg_write
  );
endinterface

// Registered record of one retired instruction
interface rv_retire_if import rv_isa_pkg::*; ();
  logic            valid;
  logic [31:0]     instr;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] rd_data;
  logic            trap;
  trap_code_t      trap_code;
  logic            reg_write;
  logic            ebreak;

  modport src (
    output valid, instr, pc, rs1_data, rs2_data, rd_data, trap, trap_code,
    output reg_write, ebreak
  );

  modport dst (
    input valid, instr, pc, rs1_data, rs2_data, rd_data, trap, trap_code,
    input reg_write, ebreak
  );
endinterface

// File: rv_mul_fixup.sv
`timescale 1ns/1ps

module rv_mul_fixup import rv_isa_pkg::*; (
  input  logic [2*xlen-1:0] product_64_i,
  input  logic [xlen-1:0]   rs1_data_i,
  input  logic [xlen-1:0]   rs2_data_i,
  input  logic [2:0]        op_i,
  output logic [xlen-1:0]   result_o
);

  logic [xlen-1:0] prod_lo;
  logic [xlen-1:0] prod_hi;
  logic            rs1_neg;
  logic            rs2_neg;
  logic [xlen-1:0] hi_su;
  logic [xlen-1:0] hi_ss;

  assign prod_lo = product_64_i[xlen-1:0];
  assign prod_hi = product_64_i[2*xlen-1:xlen];
  assign rs1_neg = rs1_data_i[xlen-1];
  assign rs2_neg = rs2_data_i[xlen-1];

  // A negative operand read as unsigned adds 2^xlen times the other operand
  // to the product, so that operand comes back off the high half
  assign hi_su = prod_hi - (rs1_neg ? rs2_data_i : '0);
  assign hi_ss = hi_su - (rs2_neg ? rs1_data_i : '0);

  always_comb begin
    case (op_i)
      mul_op_mul: begin
        result_o = prod_lo;
      end
      mul_op_mulh: begin
        result_o = hi_ss;
      end
      mul_op_mulhsu: begin
        result_o = hi_su;
      end
      mul_op_mulhu: begin
        result_o = prod_hi;
      end
      // Division codes, result is discarded by the stage
      default: begin
        result_o = prod_lo;
      end
    endcase
  end

endmodule

// File: rv_retire_credit.sv
`timescale 1ns/1ps

module rv_retire_credit import rv_wb_pkg::*; (
  input  logic clk,
  input  logic rst_n_i,
  input  logic instr_valid_i,
  input  logic stall_i,
  input  logic credit_return_i,
  output logic advance_o,
  output logic stall_o
);

  logic [credit_cnt_w-1:0] credit_cnt;
  logic                    has_credit;

  assign has_credit = (credit_cnt != '0);

  // Accept only with a free slot downstream and no hazard stall
  assign advance_o = instr_valid_i && !stall_i && has_credit;

  // Memory stage holds its bundle while a valid instruction waits
  assign stall_o = instr_valid_i && !advance_o;

  // Spend on accept, refill on return, both at once cancel out
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_cnt <= credit_cnt_w'(retire_credits);
    end else if (advance_o && !credit_return_i) begin
      credit_cnt <= credit_cnt - 1'b1;
    end else if (credit_return_i && !advance_o) begin
      credit_cnt <= credit_cnt + 1'b1;
    end
  end

  a_credit_bounded: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    credit_cnt <= credit_cnt_w'(retire_credits)
  );

  // An empty counter spends nothing until a credit comes back
  a_no_advance_empty: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    (credit_cnt == '0) && !credit_return_i |=> (credit_cnt == '0)
  );

  // Consumer cannot free more slots than it owns
  a_no_return_full: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    credit_return_i |-> (credit_cnt != credit_cnt_w'(retire_credits))
  );

endmodule

// File: rv_retire_reg.sv
`timescale 1ns/1ps

module rv_retire_reg import rv_isa_pkg::*; (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            advance_i,
  input  logic [31:0]     instr_i,
  input  logic [xlen-1:0] pc_i,
  input  logic [xlen-1:0] rs1_data_i,
  input  logic [xlen-1:0] rs2_data_i,
  input  logic [xlen-1:0] rd_data_i,
  input  logic            trap_i,
  input  trap_code_t      trap_code_i,
  input  logic            reg_write_i,
  input  logic            ebreak_i,
  rv_retire_if.src        ret
);

  // Accepted instruction or an all-zero bubble, one record per cycle
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ret.valid     <= 1'b0;
      ret.instr     <= '0;
      ret.pc        <= '0;
      ret.rs1_data  <= '0;
      ret.rs2_data  <= '0;
      ret.rd_data   <= '0;
      ret.trap      <= 1'b0;
      ret.trap_code <= '0;
      ret.reg_write <= 1'b0;
      ret.ebreak    <= 1'b0;
    end else begin
      ret.valid     <= advance_i;
      ret.instr     <= advance_i ? instr_i : '0;
      ret.pc        <= advance_i ? pc_i : '0;
      ret.rs1_data  <= advance_i ? rs1_data_i : '0;
      ret.rs2_data  <= advance_i ? rs2_data_i : '0;
      ret.rd_data   <= advance_i ? rd_data_i : '0;
      ret.trap      <= advance_i && trap_i;
      ret.trap_code <= advance_i ? trap_code_i : '0;
      ret.reg_write <= advance_i && reg_write_i;
      ret.ebreak    <= advance_i && ebreak_i;
    end
  end

endmodule

// File: rv_wb_stage.sv
`timescale 1ns/1ps

module rv_wb_stage
  import rv_isa_pkg::*;
  import rv_wb_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            stall_i,
  input  logic            credit_return_i,
  rv_wb_in_if.dst         wb,
  rv_retire_if.src        ret,
  output logic            stall_o,
  output logic [xlen-1:0] rd_data_wb_o
);

  logic [xlen-1:0] mul_result;
  logic [xlen-1:0] m_ext_result;
  logic [xlen-1:0] pc;
  logic            advance;

  rv_mul_fixup u_mul_fixup (
    .product_64_i (wb.product_64),
    .rs1_data_i   (wb.rs1_data),
    .rs2_data_i   (wb.rs2_data),
    .op_i         (wb.instr.r.funct3),
    .result_o     (mul_result)
  );

  // Divider result is finished upstream, funct3 bit 2 marks division
  assign m_ext_result = wb.instr.r.funct3[2] ? wb.m_result : mul_result;

  // Same-cycle write data for the register file
  always_comb begin
    case (wb.res_src)
      res_alu:      rd_data_wb_o = wb.alu_result;
      res_load:     rd_data_wb_o = wb.ld_data;
      res_pc_plus4: rd_data_wb_o = wb.pc_plus4;
      res_jb_tgt:   rd_data_wb_o = wb.jb_tgt;
      res_csr:      rd_data_wb_o = wb.csr_rdata;
      res_m_ext:    rd_data_wb_o = m_ext_result;
      default:      rd_data_wb_o = '0;
    endcase
  end

  // PC is not carried this far, rebuild it from the link value
  assign pc = wb.pc_plus4 - xlen'(4);

  rv_retire_credit u_retire_credit (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .instr_valid_i   (wb.instr_valid),
    .stall_i         (stall_i),
    .credit_return_i (credit_return_i),
    .advance_o       (advance),
    .stall_o         (stall_o)
  );

  rv_retire_reg u_retire_reg (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .advance_i   (advance),
    .instr_i     (wb.instr.raw),
    .pc_i        (pc),
    .rs1_data_i  (wb.rs1_data),
    .rs2_data_i  (wb.rs2_data),
    .rd_data_i   (rd_data_wb_o),
    .trap_i      (wb.trap),
    .trap_code_i (wb.trap_code),
    .reg_write_i (wb.reg_write),
    .ebreak_i    (wb.is_ebreak),
    .ret         (ret)
  );

  // Decode upstream never issues a reserved result source
  a_res_src_legal: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    wb.instr_valid |-> (wb.res_src <= res_m_ext)
  );

endmodule

// File: rv_wb_top.sv
`timescale 1ns/1ps

module rv_wb_top import rv_isa_pkg::*; (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            stall_i,
  input  logic            credit_return_i,
  input  logic            instr_valid_i,
  input  logic [2:0]      res_src_i,
  input  logic [31:0]     instr_i,
  input  logic [xlen-1:0] alu_result_i,
  input  logic [xlen-1:0] ld_data_i,
  input  logic [xlen-1:0] pc_plus4_i,
  input  logic [xlen-1:0] jb_tgt_i,
  input  logic [xlen-1:0] csr_rdata_i,
  input  logic [xlen-1:0] m_result_i,
  input  logic [xlen-1:0] rs1_data_i,
  input  logic [xlen-1:0] rs2_data_i,
  input  logic [63:0]     product_64_i,
  input  logic            trap_i,
  input  trap_code_t      trap_code_i,
  input  logic            is_ebreak_i,
  input  logic            reg_write_i,
  output logic            stall_o,
  output logic [xlen-1:0] rd_data_wb_o,
  output logic            retire_valid_o,
  output logic [31:0]     retire_instr_o,
  output logic [xlen-1:0] retire_pc_o,
  output logic [xlen-1:0] retire_rs1_data_o,
  output logic [xlen-1:0] retire_rs2_data_o,
  output logic [xlen-1:0] retire_rd_data_o,
  output logic            retire_trap_o,
  output trap_code_t      retire_trap_code_o,
  output logic            retire_reg_write_o,
  output logic            retire_ebreak_o
);

  rv_wb_in_if  wb_in ();
  rv_retire_if ret ();

  // Memory stage bundle
  assign wb_in.instr_valid = instr_valid_i;
  assign wb_in.res_src     = res_src_i;
  assign wb_in.instr       = instr_i;
  assign wb_in.alu_result  = alu_result_i;
  assign wb_in.ld_data     = ld_data_i;
  assign wb_in.pc_plus4    = pc_plus4_i;
  assign wb_in.jb_tgt      = jb_tgt_i;
  assign wb_in.csr_rdata   = csr_rdata_i;
  assign wb_in.m_result    = m_result_i;
  assign wb_in.rs1_data    = rs1_data_i;
  assign wb_in.rs2_data    = rs2_data_i;
  assign wb_in.product_64  = product_64_i;
  assign wb_in.trap        = trap_i;
  assign wb_in.trap_code   = trap_code_i;
  assign wb_in.is_ebreak   = is_ebreak_i;
  assign wb_in.reg_write   = reg_write_i;

  rv_wb_stage u_wb_stage (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .stall_i         (stall_i),
    .credit_return_i (credit_return_i),
    .wb              (wb_in.dst),
    .ret             (ret.src),
    .stall_o         (stall_o),
    .rd_data_wb_o    (rd_data_wb_o)
  );

  // Retirement record out to the consumer
  assign retire_valid_o     = ret.valid;
  assign retire_instr_o     = ret.instr;
  assign retire_pc_o        = ret.pc;
  assign retire_rs1_data_o  = ret.rs1_data;
  assign retire_rs2_data_o  = ret.rs2_data;
  assign retire_rd_data_o   = ret.rd_data;
  assign retire_trap_o      = ret.trap;
  assign retire_trap_code_o = ret.trap_code;
  assign retire_reg_write_o = ret.reg_write;
  assign retire_ebreak_o    = ret.ebreak;

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst_n_o
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset held for the first 16 rising edges
  initial begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk);
    #1 rst_n_o = 1'b1;
  end

endmodule

// File: tb_rv_wb.sv
`timescale 1ns/1ps

module tb_rv_wb
  import rv_isa_pkg::*;
  import rv_wb_pkg::*;
();

  localparam int num_rows           = 16;
  localparam int credit_test_cycles = 2 * retire_credits + 12;
  localparam int clk_period         = 10;

  typedef struct packed {
    logic        valid;
    logic [2:0]  res_src;
    logic [31:0] instr;
    logic [31:0] alu;
    logic [31:0] ld;
    logic [31:0] pc4;
    logic [31:0] jb;
    logic [31:0] csr;
    logic [31:0] m_res;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [63:0] prod;
    logic        trap;
    trap_code_t  trap_code;
    logic        ebreak;
    logic        reg_write;
    logic [31:0] exp_rd;
  } stim_row_t;

  logic        clk;
  logic        rst_n_i;
  logic        stall_i;
  logic        credit_return_i;
  logic        instr_valid_i;
  logic [2:0]  res_src_i;
  logic [31:0] instr_i;
  logic [31:0] alu_result_i;
  logic [31:0] ld_data_i;
  logic [31:0] pc_plus4_i;
  logic [31:0] jb_tgt_i;
  logic [31:0] csr_rdata_i;
  logic [31:0] m_result_i;
  logic [31:0] rs1_data_i;
  logic [31:0] rs2_data_i;
  logic [63:0] product_64_i;
  logic        trap_i;
  trap_code_t  trap_code_i;
  logic        is_ebreak_i;
  logic        reg_write_i;
  logic        stall_o;
  logic [31:0] rd_data_wb_o;
  logic        retire_valid_o;
  logic [31:0] retire_instr_o;
  logic [31:0] retire_pc_o;
  logic [31:0] retire_rs1_data_o;
  logic [31:0] retire_rs2_data_o;
  logic [31:0] retire_rd_data_o;
  logic        retire_trap_o;
  trap_code_t  retire_trap_code_o;
  logic        retire_reg_write_o;
  logic        retire_ebreak_o;

  stim_row_t rows [num_rows];
  integer    seed;
  int        errors;
  int        num_checks;

  tb_clk_gen u_clk_gen (
    .clk     (clk),
    .rst_n_o (rst_n_i)
  );

  rv_wb_top rv_wb_top_i (.*);

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
    num_checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("test %-16s done, %0d errors", name, errors - err_before);
  endtask

  // R-type word with rs1 and rs2 numbered after rd
  function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [2:0] funct3,
                                         input logic [4:0] rd);
    rv_instr_u word;
    word.raw      = '0;
    word.r.opcode = 7'b0110011;
    word.r.funct7 = funct7;
    word.r.funct3 = funct3;
    word.r.rd     = rd;
    word.r.rs1    = rd + 5'd1;
    word.r.rs2    = rd + 5'd2;
    return word.raw;
  endfunction

  task automatic build_table();
    logic [31:0]        a;
    logic [31:0]        b;
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        prod;
    logic [2:0]         f3;
    for (int i = 0; i < num_rows; i++) begin
      a = $random(seed);
      b = $random(seed);
      // Rows 8 to 11 have a negative rs1, rows 12 to 15 a negative rs2
      if (i >= 8) begin
        a[31] = (i < 12);
        b[31] = (i >= 12);
      end
      rows[i]           = '0;
      rows[i].valid     = (i != 7);
      rows[i].alu       = $random(seed);
      rows[i].ld        = $random(seed);
      rows[i].jb        = $random(seed);
      rows[i].csr       = $random(seed);
      rows[i].m_res     = $random(seed);
      rows[i].pc4       = 32'h0000_2004 + 4 * i;
      rows[i].rs1       = a;
      rows[i].rs2       = b;
      rows[i].prod      = {32'b0, a} * {32'b0, b};
      rows[i].trap      = (i % 5 == 2);
      rows[i].trap_code = i[1:0];
      rows[i].ebreak    = (i == 4);
      rows[i].reg_write = (i % 4 != 3);
      f3 = 3'b000;
      if (i < 5) begin
        rows[i].res_src = i[2:0];
        case (i)
          0: rows[i].exp_rd = rows[i].alu;
          1: rows[i].exp_rd = rows[i].ld;
          2: rows[i].exp_rd = rows[i].pc4;
          3: rows[i].exp_rd = rows[i].jb;
          default: rows[i].exp_rd = rows[i].csr;
        endcase
      end else if (i < 7) begin
        // DIV and REMU pass the divider result through
        f3 = (i == 5) ? 3'b100 : 3'b111;
        rows[i].res_src = res_m_ext;
        rows[i].exp_rd  = rows[i].m_res;
      end else if (i == 7) begin
        rows[i].res_src = res_alu;
        rows[i].exp_rd  = rows[i].alu;
      end else begin
        f3 = i[2:0] & 3'b011;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        case (f3)
          mul_op_mulh:   prod = sa * sb;
          mul_op_mulhsu: prod = sa * $signed({32'b0, b});
          default:       prod = {32'b0, a} * {32'b0, b};
        endcase
        rows[i].res_src = res_m_ext;
        rows[i].exp_rd  = (f3 == mul_op_mul) ? prod[31:0] : prod[63:32];
      end
      rows[i].instr = r_type((rows[i].res_src == res_m_ext) ? 7'd1 : 7'd0, f3, i[4:0]);
    end
  endtask

  task automatic apply_row(input stim_row_t row);
    instr_valid_i = row.valid;
    res_src_i     = row.res_src;
    instr_i       = row.instr;
    alu_result_i  = row.alu;
    ld_data_i     = row.ld;
    pc_plus4_i    = row.pc4;
    jb_tgt_i      = row.jb;
    csr_rdata_i   = row.csr;
    m_result_i    = row.m_res;
    rs1_data_i    = row.rs1;
    rs2_data_i    = row.rs2;
    product_64_i  = row.prod;
    trap_i        = row.trap;
    trap_code_i   = row.trap_code;
    is_ebreak_i   = row.ebreak;
    reg_write_i   = row.reg_write;
  endtask

  // A row that was not accepted must leave an all-zero record
  task automatic check_retire(input stim_row_t row);
    logic v;
    v = row.valid;
    compare("retire_valid_o", retire_valid_o, v);
    compare("retire_instr_o", retire_instr_o, v ? row.instr : '0);
    compare("retire_pc_o", retire_pc_o, v ? row.pc4 - 32'd4 : '0);
    compare("retire_rs1_data_o", retire_rs1_data_o, v ? row.rs1 : '0);
    compare("retire_rs2_data_o", retire_rs2_data_o, v ? row.rs2 : '0);
    compare("retire_rd_data_o", retire_rd_data_o, v ? row.exp_rd : '0);
    compare("retire_trap_o", retire_trap_o, v & row.trap);
    compare("retire_trap_code_o", retire_trap_code_o, v ? row.trap_code : '0);
    compare("retire_reg_write_o", retire_reg_write_o, v & row.reg_write);
    compare("retire_ebreak_o", retire_ebreak_o, v & row.ebreak);
  endtask

  task automatic count_retires(input int cycles, output int cnt);
    cnt = 0;
    repeat (cycles) begin
      @(posedge clk);
      #1;
      if (retire_valid_o) begin
        cnt++;
      end
    end
  endtask

  initial begin
    int start;
    int n;
    seed            = 32'h0783_07a7;
    errors          = 0;
    num_checks      = 0;
    stall_i         = 1'b0;
    credit_return_i = 1'b0;
    apply_row('0);
    build_table();

    // Sampled before the first clock edge after reset release
    @(posedge rst_n_i);
    #1;
    start = errors;
    compare("retire_valid_o", retire_valid_o, 1'b0);
    // A valid instruction right after reset finds the credits full
    apply_row(rows[0]);
    #1;
    compare("stall_o", stall_o, 1'b0);
    apply_row('0);
    report_test("reset_state", start);

    // One row per cycle, each retirement hands its credit back a cycle later
    start = errors;
    for (int i = 0; i <= num_rows; i++) begin
      @(posedge clk);
      #1;
      credit_return_i = 1'b0;
      if (i > 0) begin
        check_retire(rows[i-1]);
        credit_return_i = rows[i-1].valid;
      end
      if (i < num_rows) begin
        apply_row(rows[i]);
        #4;
        compare("rd_data_wb_o", rd_data_wb_o, rows[i].exp_rd);
      end else begin
        apply_row('0);
      end
    end
    @(posedge clk);
    #1;
    credit_return_i = 1'b0;
    report_test("table", start);

    start = errors;
    stall_i = 1'b1;
    apply_row(rows[0]);
    #1;
    compare("stall_o", stall_o, 1'b1);
    count_retires(3, n);
    compare("retire_valid_o count", n, 0);
    stall_i = 1'b0;
    apply_row('0);
    report_test("hazard_stall", start);

    start = errors;
    @(posedge clk);
    #1;
    apply_row(rows[0]);
    count_retires(retire_credits + 3, n);
    compare("retire_valid_o count", n, retire_credits);
    compare("stall_o", stall_o, 1'b1);
    compare("retire_valid_o", retire_valid_o, 1'b0);
    credit_return_i = 1'b1;
    @(posedge clk);
    #1;
    credit_return_i = 1'b0;
    count_retires(4, n);
    compare("retire_valid_o count", n, 1);
    apply_row('0);
    report_test("credit_backpressure", start);

    $display("checks: %0d, errors: %0d", num_checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    #((num_rows + credit_test_cycles) * 4 * clk_period);
    $display("Watchdog expired before the tests completed");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: compile.f
rv_isa_pkg.sv
rv_wb_pkg.sv
rv_wb_if.sv
rv_mul_fixup.sv
rv_retire_credit.sv
rv_retire_reg.sv
rv_wb_stage.sv
rv_wb_top.sv
tb_clk_gen.sv
tb_rv_wb.sv
